// ==== sim.f ====
rtl/fetch_pkg.sv
rtl/instr_mem.sv
rtl/hwloop_unit.sv
rtl/fetch_ctrl.sv
rtl/if_stage.sv
rtl/fetch_top.sv
verif/tb_clk_gen.sv
verif/fetch_tb.sv

// ==== verif/fetch_tb.sv ====
/*
 * Testbench for the instruction fetch subsystem.
 * Preloads the RAM with random words, then runs random phases for boot,
 * stall and force-NOP, jumps, interrupts and the hardware loop. A cycle
 * model predicts the IF PC and IF/ID output, compared on each falling edge.
 */

`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;

  localparam logic [31:0] NOP_WORD     = 32'h0000_0013;  // addi x0, x0, 0
  localparam int unsigned DEPTH        = 256;
  localparam int unsigned RST_TIMEOUT  = 50;
  localparam int unsigned LOOP_TIMEOUT = 400;

  logic               clk;
  logic               rst_n;
  logic [31:0]        boot_addr;
  logic               irq;
  logic               irq_nm;
  logic               mret;
  logic               stall;
  logic               force_nop;
  jump_req_t          jump;
  hwloop_cfg_t        hwl_cfg;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_waddr;
  logic [31:0]        imem_wdata;
  logic [31:0]        pc_if;
  if_id_t             if_id;

  // Staged inputs, applied on the next rising edge
  logic               n_stall;
  logic               n_fnop;
  logic               n_irq;
  logic               n_irq_nm;
  logic               n_mret;
  logic               n_we;
  logic [IMEM_AW-1:0] n_waddr;
  logic [31:0]        n_wdata;
  jump_req_t          n_jump;
  hwloop_cfg_t        n_cfg;

  // Reference model state
  logic [31:0]        mem_copy [DEPTH];
  logic [31:0]        m_pc;
  logic [31:0]        m_epc;
  logic [31:0]        m_hstart;
  logic [31:0]        m_hend;
  logic [15:0]        m_hcnt;
  logic               m_boot;               // Boot load still pending
  if_id_t             m_ifid;
  bit                 model_on;

  int unsigned        checks;
  int unsigned        errors;
  int unsigned        test_errs;
  string              test_name;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_top fetch_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .boot_addr_i  (boot_addr),
    .irq_i        (irq),
    .irq_nm_i     (irq_nm),
    .mret_i       (mret),
    .stall_i      (stall),
    .force_nop_i  (force_nop),
    .jump_i       (jump),
    .hwl_cfg_i    (hwl_cfg),
    .imem_we_i    (imem_we),
    .imem_waddr_i (imem_waddr),
    .imem_wdata_i (imem_wdata),
    .pc_if_o      (pc_if),
    .if_id_o      (if_id)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic one_in(input int unsigned n);
    return ($urandom % n) == 0;
  endfunction

  function automatic logic [31:0] rand_word_addr();
    return $urandom & 32'hFFFF_FFFC;        // Word aligned
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      test_errs++;
      $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    $display("test %-12s done, %0d errors", test_name, test_errs);
  endtask

  task automatic set_idle();
    n_stall  = 1'b0;
    n_fnop   = 1'b0;
    n_irq    = 1'b0;
    n_irq_nm = 1'b0;
    n_mret   = 1'b0;
    n_we     = 1'b0;
    n_jump   = '0;                          // JUMP_NONE
    n_cfg    = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, one rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_update();
    logic [31:0] ctrl_pc;
    logic [31:0] nxt;
    logic        free;
    logic        req;
    logic        save;
    logic        taken;
    req     = (m_pc == m_hend) && (m_hcnt > 16'd1);
    free    = !m_boot && !stall && (jump.kind == JUMP_NONE);  // Controller may act
    ctrl_pc = m_pc + 32'd4;
    save    = 1'b0;
    taken   = 1'b0;
    if (irq_nm || irq)
    begin
      ctrl_pc = {boot_addr[31:8], irq_nm ? 8'h04 : 8'h00};  // NMI wins
      save    = 1'b1;
    end
    else if (mret)
      ctrl_pc = m_epc;
    else if (req)
    begin
      ctrl_pc = m_hstart;
      taken   = 1'b1;
    end
    if (m_boot)
      nxt = boot_addr;
    else if (jump.kind == JUMP_UNCOND)
      nxt = jump.target;                    // Even under stall
    else if (jump.kind == JUMP_BRANCH)
      nxt = jump.taken ? jump.target : m_pc;
    else if (stall || force_nop)
      nxt = m_pc;
    else
      nxt = ctrl_pc;
    if (!stall)
    begin
      m_ifid.instr = force_nop ? NOP_WORD : mem_copy[m_pc[IMEM_AW+1:2]];
      m_ifid.pc    = m_pc;
    end
    // Controller side effects also happen when force-NOP holds the PC
    if (free && save)
      m_epc = m_pc;
    if (hwl_cfg.we)
    begin
      m_hstart = hwl_cfg.start;
      m_hend   = hwl_cfg.end_addr;
      m_hcnt   = hwl_cfg.count;
    end
    else if (free && taken)
      m_hcnt = m_hcnt - 16'd1;
    m_pc   = nxt;
    m_boot = 1'b0;
  endtask

  // One clock: drive staged inputs, advance model, compare at the falling edge
  task automatic step();
    @(posedge clk);
    if (model_on)
      model_update();                       // Sees the inputs the DUT just sampled
    stall      <= n_stall;
    force_nop  <= n_fnop;
    irq        <= n_irq;
    irq_nm     <= n_irq_nm;
    mret       <= n_mret;
    jump       <= n_jump;
    hwl_cfg    <= n_cfg;
    imem_we    <= n_we;
    imem_waddr <= n_waddr;
    imem_wdata <= n_wdata;
    set_idle();
    @(negedge clk);
    if (model_on)
    begin
      check("pc", m_pc, pc_if);
      check("if_id", m_ifid, if_id);
    end
  endtask

  task automatic preload_word(input int unsigned idx);
    logic [31:0] w;
    w             = $urandom;
    mem_copy[idx] = w;
    n_we          = 1'b1;
    n_waddr       = idx[IMEM_AW-1:0];
    n_wdata       = w;
    n_stall       = 1'b1;                   // Keep fetch parked until RAM is full
    step();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    int unsigned seed;
    int unsigned n;
    int unsigned k;
    int unsigned returns;
    logic [15:0] cnt;
    logic [31:0] start;
    logic [31:0] prev_pc;
    seed = 32'h982d;
    void'($urandom(seed));
    boot_addr  = rand_word_addr();
    stall      = 1'b1;
    force_nop  = 1'b0;
    irq        = 1'b0;
    irq_nm     = 1'b0;
    mret       = 1'b0;
    jump       = '0;
    hwl_cfg    = '0;
    imem_we    = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    n_waddr    = '0;
    n_wdata    = '0;
    set_idle();
    m_pc     = '0;                          // Reset values
    m_epc    = '0;
    m_hstart = '0;
    m_hend   = '0;
    m_hcnt   = '0;
    m_boot   = 1'b1;
    m_ifid   = '0;
    model_on = 1'b0;
    checks   = 0;
    errors   = 0;
    begin_test("preload");

    n = 0;
    while (rst_n !== 1'b1 && n < RST_TIMEOUT)  // Fill RAM while reset is held
    begin
      preload_word(n);
      n++;
    end

    if (rst_n !== 1'b1)
    begin
      $display("ERROR: reset was not released within %0d cycles", RST_TIMEOUT);
      errors++;
    end
    else
    begin
      model_on = 1'b1;
      for (int unsigned i = n; i < DEPTH; i++)
        preload_word(i);
      n_stall = 1'b1;                       // Let the read at the boot PC settle
      step();
      end_test();

      begin_test("boot_seq");
      check("boot pc", boot_addr, pc_if);
      repeat (24) step();
      end_test();

      begin_test("stall_nop");
      repeat (48)
      begin
        n_stall = one_in(3);
        n_fnop  = one_in(4);
        step();
      end
      end_test();

      begin_test("jump_branch");
      repeat (48)
      begin
        k       = $urandom % 4;
        n_stall = one_in(3);
        if (k == 0)
          n_jump.kind = JUMP_UNCOND;
        else if (k == 1)
          n_jump.kind = JUMP_BRANCH;
        n_jump.target = rand_word_addr();
        n_jump.taken  = $urandom % 2;
        step();
      end
      end_test();

      begin_test("irq_mret");
      n_irq = 1'b1;                         // Plain irq, then return
      step();
      repeat (3) step();
      n_mret = 1'b1;
      step();
      repeat (2) step();
      n_irq    = 1'b1;                      // Both at once
      n_irq_nm = 1'b1;
      step();
      step();
      n_mret = 1'b1;
      step();
      repeat (48)
      begin
        n_irq    = one_in(8);
        n_irq_nm = one_in(10);
        n_mret   = one_in(8);
        n_stall  = one_in(4);
        n_fnop   = one_in(6);
        step();
      end
      end_test();

      begin_test("hwloop");
      repeat (3)
      begin
        start          = rand_word_addr();
        k              = 1 + $urandom % 6;   // Loop body of k+1 words
        cnt            = 2 + $urandom % 4;
        n_cfg.we       = 1'b1;
        n_cfg.start    = start;
        n_cfg.end_addr = start + 4 * k;
        n_cfg.count    = cnt;
        n_jump.kind    = JUMP_UNCOND;        // Enter the loop body
        n_jump.target  = start;
        step();
        returns = 0;
        n       = 0;
        prev_pc = pc_if;
        while (pc_if !== start + 4 * (k + 1) && n < LOOP_TIMEOUT)
        begin
          n_stall = one_in(4);
          step();
          if (prev_pc == start + 4 * k && pc_if == start)
            returns++;
          prev_pc = pc_if;
          n++;
        end
        if (n >= LOOP_TIMEOUT)
        begin
          $display("ERROR: hardware loop did not fall through within %0d cycles",
                   LOOP_TIMEOUT);
          errors++;
          test_errs++;
        end
        check("loop returns", cnt - 16'd1, returns);
      end
      end_test();
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
/*
 * Testbench clock and reset source.
 * 8 ns clock, active-low reset held for the first 10 rising edges.
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam time HALF_PERIOD = 4ns;
  localparam int unsigned RST_CYCLES = 10;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                      // Released on an edge, DUT runs from the next one
  end

endmodule

// ==== rtl/fetch_top.sv ====
/*
 * Instruction fetch subsystem top level.
 * Connects the fetch controller, hardware-loop unit, IF stage and the
 * instruction RAM. Events, jumps, loop configuration and the RAM preload
 * port come straight from the ports.
 */

`timescale 1ns/1ps

module fetch_top (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [31:0]                   boot_addr_i,

  // Events and pipeline control
  input  logic                          irq_i,
  input  logic                          irq_nm_i,
  input  logic                          mret_i,
  input  logic                          stall_i,
  input  logic                          force_nop_i,
  input  fetch_pkg::jump_req_t          jump_i,
  input  fetch_pkg::hwloop_cfg_t        hwl_cfg_i,

  // RAM preload
  input  logic                          imem_we_i,
  input  logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_i,
  input  logic [31:0]                   imem_wdata_i,

  output logic [31:0]                   pc_if_o,
  output fetch_pkg::if_id_t             if_id_o
);

  import fetch_pkg::*;

  fetch_ctrl_t ctrl;
  logic [31:0] pc_if;
  logic        hwl_req;
  logic [31:0] hwl_target;
  logic        hwl_taken;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;

  assign pc_if_o = pc_if;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////
  fetch_ctrl fetch_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_i        (irq_i),
    .irq_nm_i     (irq_nm_i),
    .mret_i       (mret_i),
    .stall_i      (stall_i),
    .jump_kind_i  (jump_i.kind),
    .pc_if_i      (pc_if),
    .hwl_req_i    (hwl_req),
    .hwl_target_i (hwl_target),
    .hwl_taken_o  (hwl_taken),
    .ctrl_o       (ctrl)
  );

  hwloop_unit hwloop_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_i    (hwl_cfg_i),
    .pc_if_i  (pc_if),
    .taken_i  (hwl_taken),
    .req_o    (hwl_req),
    .target_o (hwl_target)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////
  if_stage if_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .boot_addr_i   (boot_addr_i),
    .ctrl_i        (ctrl),
    .jump_i        (jump_i),
    .force_nop_i   (force_nop_i),
    .stall_i       (stall_i),
    .instr_rdata_i (instr_rdata),
    .instr_addr_o  (instr_addr),
    .pc_if_o       (pc_if),
    .if_id_o       (if_id_o)
  );

  instr_mem instr_mem_inst (
    .clk     (clk),
    .addr_i  (instr_addr),
    .rdata_o (instr_rdata),
    .we_i    (imem_we_i),
    .waddr_i (imem_waddr_i),
    .wdata_i (imem_wdata_i)
  );

endmodule

// ==== rtl/if_stage.sv ====
/*
 * Instruction fetch stage.
 * Picks the next PC from boot, EX jumps and branches, stall, force-NOP and
 * the controller's PC-mux code, and drives it straight out as the fetch
 * address so the synchronous RAM returns the word of the current IF PC.
 * The fetched word and its PC are sampled into the IF/ID register, which
 * freezes on stall and carries the canonical NOP under force-NOP.
 */

`timescale 1ns/1ps

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic [31:0]            boot_addr_i,     // Base of the exception vectors too

  // Controller and EX side
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  fetch_pkg::jump_req_t   jump_i,
  input  logic                   force_nop_i,     // Bubble into ID, PC held
  input  logic                   stall_i,         // Freezes PC and IF/ID

  // Instruction memory
  input  logic [31:0]            instr_rdata_i,   // Word at current IF PC
  output logic [31:0]            instr_addr_o,    // PC of the next cycle

  // Pipeline outputs
  output logic [31:0]            pc_if_o,
  output fetch_pkg::if_id_t      if_id_o
);

  import fetch_pkg::*;

  logic [31:0] pc_q;          // IF program counter
  logic [31:0] exc_pc;        // Selected exception vector
  logic [31:0] mux_pc;        // PC requested by the controller
  logic [31:0] next_pc;       // Final next PC after all overrides
  logic [31:0] instr_int;     // Fetched word or NOP
  if_id_t      if_id_q;

  assign pc_if_o      = pc_q;
  assign if_id_o      = if_id_q;
  assign instr_addr_o = next_pc;  // Fetch ahead so read data lines up with pc_q

  ////////////////////////////////////////////////////////////////////////////
  // Exception vector
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    unique case (ctrl_i.exc_sel)
      EXC_SEL_IRQ:    exc_pc = {boot_addr_i[31:8], EXC_OFF_IRQ};
      EXC_SEL_IRQ_NM: exc_pc = {boot_addr_i[31:8], EXC_OFF_IRQ_NM};
      default:        exc_pc = pc_q;      // EXC_SEL_NO_INCR
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    unique case (ctrl_i.pc_mux_sel)
      PC_INCR:      mux_pc = pc_q + 32'd4;
      PC_NO_INCR:   mux_pc = pc_q;
      PC_EXCEPTION: mux_pc = exc_pc;
      PC_EXC_REG:   mux_pc = ctrl_i.epc;  // Return from exception
      PC_HWLOOP:    mux_pc = ctrl_i.epc;  // Loop start rides on the same field
      default:      mux_pc = pc_q;
    endcase
  end

  // Overrides, highest priority first
  always_comb
  begin
    if (ctrl_i.pc_boot)
    begin
      next_pc = boot_addr_i;              // First cycle out of reset
    end
    else if (jump_i.kind == JUMP_UNCOND)
    begin
      next_pc = jump_i.target;            // Wins even over stall
    end
    else if (jump_i.kind == JUMP_BRANCH)
    begin
      next_pc = jump_i.taken ? jump_i.target : pc_q;
    end
    else if (stall_i || force_nop_i)
    begin
      next_pc = pc_q;                     // Hold
    end
    else
    begin
      next_pc = mux_pc;
    end
  end

  assign instr_int = force_nop_i ? NOP_INSTR : instr_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // PC register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_q <= '0;
    end
    else
    begin
      pc_q <= next_pc;                    // Hold cases already folded into next_pc
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID pipeline register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      if_id_q <= '0;
    end
    else if (!stall_i)
    begin
      if_id_q.instr <= instr_int;
      if_id_q.pc    <= pc_q;              // PC the word was fetched from
    end
  end

endmodule

// ==== rtl/fetch_ctrl.sv ====
/*
 * Fetch controller.
 * Issues the boot load once after reset, then turns interrupt, NMI,
 * return-from-exception and hardware-loop requests into the PC-mux and
 * exception-vector codes for the IF stage. Events are only taken while the
 * pipe is neither stalled nor redirected by EX. Keeps the exception PC.
 */

`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // Events
  input  logic                   irq_i,
  input  logic                   irq_nm_i,        // Wins over irq_i
  input  logic                   mret_i,

  // Pipeline status
  input  logic                   stall_i,
  input  fetch_pkg::jump_e       jump_kind_i,
  input  logic [31:0]            pc_if_i,         // Captured as EPC

  // Hardware loop
  input  logic                   hwl_req_i,
  input  logic [31:0]            hwl_target_i,
  output logic                   hwl_taken_o,

  output fetch_pkg::fetch_ctrl_t ctrl_o
);

  import fetch_pkg::*;

  typedef enum logic {
    BOOT,                                         // First cycle after reset
    RUN
  } ctrl_state_e;

  ctrl_state_e state_q;
  logic        free;          // Controller may redirect this cycle
  logic        save_epc;
  logic [31:0] epc_q;
  pc_mux_e     pc_mux_sel;
  exc_sel_e    exc_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Boot sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= BOOT;
    end
    else
    begin
      state_q <= RUN;                             // Boot load is a one-shot
    end
  end

  assign free = (state_q == RUN) && !stall_i && (jump_kind_i == JUMP_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // Event priority
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    pc_mux_sel  = PC_NO_INCR;                     // Boot, stall or EX jump
    exc_sel     = EXC_SEL_NO_INCR;
    save_epc    = 1'b0;
    hwl_taken_o = 1'b0;
    if (free)
    begin
      if (irq_nm_i || irq_i)
      begin
        pc_mux_sel = PC_EXCEPTION;
        exc_sel    = irq_nm_i ? EXC_SEL_IRQ_NM : EXC_SEL_IRQ;
        save_epc   = 1'b1;                        // Interrupted PC
      end
      else if (mret_i)
      begin
        pc_mux_sel = PC_EXC_REG;
      end
      else if (hwl_req_i)
      begin
        pc_mux_sel  = PC_HWLOOP;
        hwl_taken_o = 1'b1;                       // Loop unit counts it down
      end
      else
      begin
        pc_mux_sel = PC_INCR;
      end
    end
  end

  // Exception PC
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      epc_q <= '0;
    end
    else if (save_epc)
    begin
      epc_q <= pc_if_i;
    end
  end

  assign ctrl_o.pc_mux_sel = pc_mux_sel;
  assign ctrl_o.exc_sel    = exc_sel;
  assign ctrl_o.pc_boot    = (state_q == BOOT);
  assign ctrl_o.epc        = (pc_mux_sel == PC_HWLOOP) ? hwl_target_i : epc_q;  // Shared field

endmodule

// ==== rtl/hwloop_unit.sv ====
/*
 * One-level hardware loop.
 * Holds loop start, end and remaining count, loaded together from cfg_i.
 * Requests a jump back to start whenever the IF PC sits on the end address
 * and more than one iteration is left. Count drops on each taken redirect.
 */

`timescale 1ns/1ps

module hwloop_unit (
  input  logic                   clk,
  input  logic                   rst_n,

  input  fetch_pkg::hwloop_cfg_t cfg_i,
  input  logic [31:0]            pc_if_i,   // Current IF PC
  input  logic                   taken_i,   // Controller accepted our request

  output logic                   req_o,
  output logic [31:0]            target_o
);

  import fetch_pkg::*;

  logic [31:0] start_q;
  logic [31:0] end_q;
  logic [15:0] count_q;     // Zero after reset, loop idle
  logic        at_end;

  assign at_end   = (pc_if_i == end_q);
  assign req_o    = at_end && (count_q > 16'd1);  // Last pass falls through
  assign target_o = start_q;

  // Loop bounds
  always_ff @(posedge clk)
  begin
    if (cfg_i.we)
    begin
      start_q <= cfg_i.start;
      end_q   <= cfg_i.end_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Iteration counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q <= '0;
    end
    else if (cfg_i.we)
    begin
      count_q <= cfg_i.count;             // New config restarts the loop
    end
    else if (taken_i && (count_q != '0))
    begin
      count_q <= count_q - 16'd1;         // One redirect done
    end
  end

endmodule

// ==== rtl/instr_mem.sv ====
/*
 * Instruction RAM, one 32-bit word per entry.
 * Read is synchronous: data for addr_i appears one cycle later.
 * Byte addresses wrap modulo the array size.
 * The write port takes a word address and is meant for preloading.
 */

`timescale 1ns/1ps

module instr_mem (
  input  logic                         clk,

  // Fetch port
  input  logic [31:0]                  addr_i,    // Byte address
  output logic [31:0]                  rdata_o,

  // Preload port
  input  logic                         we_i,
  input  logic [fetch_pkg::IMEM_AW-1:0] waddr_i,  // Word address
  input  logic [31:0]                  wdata_i
);

  import fetch_pkg::*;

  localparam int unsigned DEPTH = 2 ** IMEM_AW;

  logic [31:0]         mem [DEPTH];
  logic [IMEM_AW-1:0]  raddr;             // Word index, upper bits dropped

  assign raddr = addr_i[IMEM_AW+1:2];

  // Preload write
  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read, old data on a same-cycle write
  always_ff @(posedge clk)
  begin
    rdata_o <= mem[raddr];
  end

endmodule

// ==== rtl/fetch_pkg.sv ====
/*
 * Shared types and constants for the instruction fetch subsystem.
 * Holds the PC-mux and exception-vector codes, the EX jump kind, the
 * exception vector offsets, the canonical NOP word and the packed structs
 * that carry control, jump, hardware-loop and IF/ID bundles between blocks.
 * Modules import it inside their body and use scoped names in port lists.
 */

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned IMEM_AW = 8;              // Word address bits, 256 words

  localparam logic [6:0]  OPCODE_OPIMM = 7'h13;     // Register-immediate ALU ops
  localparam logic [31:0] NOP_INSTR    = {25'b0, OPCODE_OPIMM};  // addi x0, x0, 0

  // Low byte of the exception vectors, upper bits come from the boot address
  localparam logic [7:0]  EXC_OFF_IRQ    = 8'h00;
  localparam logic [7:0]  EXC_OFF_IRQ_NM = 8'h04;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    PC_INCR      = 3'd0,                            // Sequential fetch
    PC_NO_INCR   = 3'd1,                            // Hold current PC
    PC_EXCEPTION = 3'd2,                            // Jump to exception vector
    PC_EXC_REG   = 3'd3,                            // Return to saved exception PC
    PC_HWLOOP    = 3'd4                             // Back to hardware-loop start
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_SEL_IRQ     = 2'd0,
    EXC_SEL_IRQ_NM  = 2'd1,
    EXC_SEL_NO_INCR = 2'd2                          // No vector, keep current PC
  } exc_sel_e;

  typedef enum logic [1:0] {
    JUMP_NONE   = 2'd0,
    JUMP_UNCOND = 2'd1,                             // jal / jalr resolved in EX
    JUMP_BRANCH = 2'd2                              // Conditional, see taken flag
  } jump_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    pc_mux_e     pc_mux_sel;
    exc_sel_e    exc_sel;
    logic        pc_boot;                           // Load boot address this cycle
    logic [31:0] epc;                               // Saved EPC, or loop start on PC_HWLOOP
  } fetch_ctrl_t;

  typedef struct packed {
    jump_e       kind;
    logic [31:0] target;
    logic        taken;                             // Branch decision, ignored for jumps
  } jump_req_t;

  typedef struct packed {
    logic        we;                                // Load all three loop registers
    logic [31:0] start;
    logic [31:0] end_addr;                          // Address of last loop instruction
    logic [15:0] count;                             // Iterations, 0 or 1 means no redirect
  } hwloop_cfg_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_t;

endpackage
